/* common/nocPkg.sv */
`default_nettype none

package nocPkg;

  localparam int numPorts = 5;
  localparam int stateWidth = numPorts + 1;
  localparam int flitWidth = 16;
  localparam int kindWidth = 3;
  localparam int quantumWidth = 12;
  localparam int portIdxWidth = 3;

  localparam int fifoDepth = 4;
  localparam int fifoPtrWidth = $clog2(fifoDepth);
  localparam int fifoCountWidth = $clog2(fifoDepth + 1);

  // One-hot flit kinds.
  localparam logic [kindWidth-1:0] kindHead = 3'b001;
  localparam logic [kindWidth-1:0] kindBody = 3'b010;
  localparam logic [kindWidth-1:0] kindTail = 3'b100;

  // Input order, also the round-robin order.
  localparam int portL = 0;
  localparam int portN = 1;
  localparam int portE = 2;
  localparam int portW = 3;
  localparam int portS = 4;

  typedef struct packed {
    logic [kindWidth-1:0] kind;
    logic [flitWidth-kindWidth-quantumWidth-1:0] spare;
    logic [quantumWidth-1:0] quantum;
  } headView_t;

  typedef struct packed {
    logic [kindWidth-1:0] kind;
    logic [flitWidth-kindWidth-1:0] payload;
  } bodyView_t;

  // Kind bits line up in both views.
  typedef union packed {
    headView_t headView;
    bodyView_t bodyView;
  } flit_t;

  typedef logic [portIdxWidth-1:0] portIdx_t;

endpackage

`default_nettype wire

/* common/portLink.sv */
`default_nettype none

interface portLink;
  import nocPkg::*;

  logic valid;
  flit_t flit;
  logic timesUp;
  logic ready;
  // High while the arbiter keeps this port as owner.
  logic ownerHold;

  modport port
  (
    output valid,
    output flit,
    output timesUp,
    input  ready,
    input  ownerHold
  );

  modport arb
  (
    input  valid,
    input  flit,
    input  timesUp,
    output ready,
    output ownerHold
  );

endinterface

`default_nettype wire

/* inputPort/portFifo.sv */
`default_nettype none

module portFifo
(
  input  logic          clk,
  input  logic          rst,
  input  logic          wrValid,
  output logic          wrReady,
  input  nocPkg::flit_t wrFlit,
  output logic          rdValid,
  input  logic          rdReady,
  output nocPkg::flit_t rdFlit
);
  import nocPkg::*;

  flit_t mem [fifoDepth];
  logic [fifoPtrWidth-1:0] wrPtr;
  logic [fifoPtrWidth-1:0] rdPtr;
  logic [fifoCountWidth-1:0] count;
  logic full;
  logic wrEn;
  logic rdEn;

  function automatic logic [fifoPtrWidth-1:0] nextPtr(input logic [fifoPtrWidth-1:0] ptr);
    if (ptr == fifoPtrWidth'(fifoDepth - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full = (count == fifoCountWidth'(fifoDepth));
  assign rdValid = (count != '0);
  assign rdEn = rdValid && rdReady;
  // When full, a word can still enter as the head leaves.
  assign wrReady = !full || rdEn;
  assign wrEn = wrValid && wrReady;
  assign rdFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (wrEn)
      mem[wrPtr] <= wrFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (wrEn)
        wrPtr <= nextPtr(wrPtr);
      if (rdEn)
        rdPtr <= nextPtr(rdPtr);
      if (wrEn && !rdEn)
        count <= count + 1'b1;
      else if (rdEn && !wrEn)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* inputPort/holdTimer.sv */
`default_nettype none

module holdTimer
(
  input  logic          clk,
  input  logic          rst,
  input  nocPkg::flit_t headFlit,
  input  logic          headValid,
  input  logic          ownerHold,
  output logic          timesUp
);
  import nocPkg::*;

  logic [quantumWidth-1:0] quantum;
  logic [quantumWidth-1:0] count;
  logic headSeen;

  assign headSeen = headValid && (headFlit.headView.kind == kindHead);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      quantum <= '0;
      count <= '0;
    end
    else
    begin
      // Newest head at the FIFO output sets the quantum.
      if (headSeen)
        quantum <= headFlit.headView.quantum;
      if (ownerHold)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // Count starts at 0, so a port gets quantum + 1 owned cycles.
  assign timesUp = (count == quantum);

endmodule

`default_nettype wire

/* inputPort/inputPort.sv */
`default_nettype none

module inputPort
(
  input  logic          clk,
  input  logic          rst,
  input  logic          inValid,
  output logic          inReady,
  input  nocPkg::flit_t inFlit,
  portLink.port         link
);

  portFifo u_fifo
  (
    .clk     (clk),
    .rst     (rst),
    .wrValid (inValid),
    .wrReady (inReady),
    .wrFlit  (inFlit),
    .rdValid (link.valid),
    .rdReady (link.ready),
    .rdFlit  (link.flit)
  );

  // Timer watches the FIFO head and runs while the arbiter holds us.
  holdTimer u_timer
  (
    .clk       (clk),
    .rst       (rst),
    .headFlit  (link.flit),
    .headValid (link.valid),
    .ownerHold (link.ownerHold),
    .timesUp   (link.timesUp)
  );

endmodule

`default_nettype wire

/* arbiter/switchArbiter.sv */
`default_nettype none

module switchArbiter
(
  input  logic             clk,
  input  logic             rst,
  portLink.arb             links [nocPkg::numPorts],
  output logic             selValid,
  input  logic             selReady,
  output nocPkg::flit_t    selFlit,
  output nocPkg::portIdx_t selSource
);
  import nocPkg::*;

  // Bit 0 is idle, bit p+1 means port p owns the output.
  logic [stateWidth-1:0] state;
  logic [stateWidth-1:0] nextState;
  logic [numPorts-1:0] req;
  logic [numPorts-1:0] timesUp;
  logic [numPorts-1:0] ownerHold;
  flit_t flits [numPorts];

  // First requester among span ports, starting at first and wrapping.
  function automatic logic [stateWidth-1:0] pickNext(
    input logic [numPorts-1:0] reqs,
    input int first,
    input int span
  );
    logic [stateWidth-1:0] pick;
    int idx;
    pick = stateWidth'(1);
    for (int k = span - 1; k >= 0; k--)
    begin
      idx = (first + k) % numPorts;
      if (reqs[idx])
        pick = stateWidth'(1) << (idx + 1);
    end
    return pick;
  endfunction

  for (genvar i = 0; i < numPorts; i++)
  begin : gLink
    assign req[i] = links[i].valid;
    assign timesUp[i] = links[i].timesUp;
    assign flits[i] = links[i].flit;
    assign links[i].ownerHold = ownerHold[i];
    assign links[i].ready = state[i + 1] && req[i] && selReady;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stateWidth'(1);
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = stateWidth'(1);
    ownerHold = '0;
    if (state[0])
      nextState = pickNext(req, 0, numPorts);
    for (int p = 0; p < numPorts; p++)
    begin
      if (state[p + 1])
      begin
        if (req[p] && !timesUp[p])
        begin
          ownerHold[p] = 1'b1;
          nextState = stateWidth'(1) << (p + 1);
        end
        else
          nextState = pickNext(req, p + 1, numPorts - 1);
      end
    end
  end

  // Owner's flit and index toward the slice.
  always_comb
  begin
    selValid = 1'b0;
    selFlit = '0;
    selSource = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      if (state[p + 1])
      begin
        selValid = req[p];
        selFlit = flits[p];
        selSource = portIdx_t'(p);
      end
    end
  end

endmodule

`default_nettype wire

/* source/outputSlice.sv */
`default_nettype none

module outputSlice
(
  input  logic             clk,
  input  logic             rst,
  input  logic             inValid,
  output logic             inReady,
  input  nocPkg::flit_t    inFlit,
  input  nocPkg::portIdx_t inSource,
  output logic             outValid,
  input  logic             outReady,
  output nocPkg::flit_t    outFlit,
  output nocPkg::portIdx_t outSource
);

  logic full;

  // Room when empty or when the held flit leaves this cycle.
  assign inReady = !full || outReady;
  assign outValid = full;

  always_ff @(posedge clk)
  begin
    if (rst)
      full <= 1'b0;
    else if (inReady)
      full <= inValid;
  end

  always_ff @(posedge clk)
  begin
    if (inValid && inReady)
    begin
      outFlit <= inFlit;
      outSource <= inSource;
    end
  end

endmodule

`default_nettype wire

/* source/nocOutputPort.sv */
`default_nettype none

module nocOutputPort
(
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic [nocPkg::numPorts-1:0]                        inValid,
  output logic [nocPkg::numPorts-1:0]                        inReady,
  input  logic [nocPkg::numPorts-1:0][nocPkg::flitWidth-1:0] inFlit,
  output logic                                               outValid,
  input  logic                                               outReady,
  output logic [nocPkg::flitWidth-1:0]                       outFlit,
  output logic [nocPkg::portIdxWidth-1:0]                    outSource
);
  import nocPkg::*;

  logic selValid;
  logic selReady;
  flit_t selFlit;
  portIdx_t selSource;

  portLink links [numPorts] ();

  // Inputs in L, N, E, W, S order.
  for (genvar i = 0; i < numPorts; i++)
  begin : gPort
    inputPort u_inputPort
    (
      .clk     (clk),
      .rst     (rst),
      .inValid (inValid[i]),
      .inReady (inReady[i]),
      .inFlit  (flit_t'(inFlit[i])),
      .link    (links[i])
    );
  end

  switchArbiter u_switchArbiter
  (
    .clk       (clk),
    .rst       (rst),
    .links     (links),
    .selValid  (selValid),
    .selReady  (selReady),
    .selFlit   (selFlit),
    .selSource (selSource)
  );

  outputSlice u_outputSlice
  (
    .clk       (clk),
    .rst       (rst),
    .inValid   (selValid),
    .inReady   (selReady),
    .inFlit    (selFlit),
    .inSource  (selSource),
    .outValid  (outValid),
    .outReady  (outReady),
    .outFlit   (outFlit),
    .outSource (outSource)
  );

endmodule

`default_nettype wire

/* verif/nocOutputPort_checker.sv */
`default_nettype none

module nocOutputPort_checker
#(
  parameter bit arbiterSide = 1'b0
)
(
  input logic                             clk,
  input logic                             rst,
  input logic [nocPkg::stateWidth-1:0]    state,
  input logic [nocPkg::numPorts-1:0]      valid,
  input logic [nocPkg::numPorts-1:0]      ready,
  input logic                             outValid,
  input logic                             outReady,
  input logic [nocPkg::flitWidth-1:0]     outFlit,
  input logic [nocPkg::portIdxWidth-1:0]  outSource
);
  timeunit 1ns;
  timeprecision 100ps;

  int failures = 0;

  if (arbiterSide)
  begin : gArb
    stateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else
    begin
      failures++;
      $error("Arbiter state %b is not one-hot", state);
    end

    // Only the owner may see ready.
    singleReady: assert property (@(posedge clk) disable iff (rst) $onehot0(ready))
    else
    begin
      failures++;
      $error("More than one link has ready high, ready %b", ready);
    end

    readyNeedsValid: assert property (@(posedge clk) disable iff (rst) (ready & ~valid) == '0)
    else
    begin
      failures++;
      $error("Ready %b is high on a link without valid %b", ready, valid);
    end
  end
  else
  begin : gOut
    // Stalled output holds its word.
    outputStable: assert property (@(posedge clk) disable iff (rst)
      outValid && !outReady |=> outValid && $stable(outFlit) && $stable(outSource))
    else
    begin
      failures++;
      $error("Output changed while stalled, outFlit %h outSource %h", outFlit, outSource);
    end
  end

endmodule

`default_nettype wire

/* verif/nocOutputPort_tb.sv */
`default_nettype none

module nocOutputPort_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import nocPkg::*;

  localparam int maxFlits = 32;
  localparam int vecWords = 128;

  logic clk;
  logic rst;
  logic [numPorts-1:0] inValid;
  logic [numPorts-1:0] inReady;
  logic [numPorts-1:0][flitWidth-1:0] inFlit;
  logic outValid;
  logic outReady;
  logic [flitWidth-1:0] outFlit;
  logic [portIdxWidth-1:0] outSource;

  logic [35:0] vecMem [vecWords];
  logic [flitWidth-1:0] stream [numPorts][maxFlits];
  int streamLen [numPorts];
  int sentPtr [numPorts];
  int recvPtr [numPorts];
  int portQuantum [numPorts];
  logic [numPorts-1:0] accepted;
  logic [2:0] flags;
  logic [31:0] readyPattern;
  logic [31:0] lfsr;
  int cycleLimit;
  int phaseCycle;
  int valueErrors;
  int orderErrors;
  int otherErrors;
  logic inRun;
  int runSource;
  int runLen;

  nocOutputPort u_nocOutputPort
  (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inReady   (inReady),
    .inFlit    (inFlit),
    .outValid  (outValid),
    .outReady  (outReady),
    .outFlit   (outFlit),
    .outSource (outSource)
  );

  bind switchArbiter nocOutputPort_checker #(.arbiterSide(1'b1)) u_arbChecker
  (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .valid     (req),
    .ready     ({links[4].ready, links[3].ready, links[2].ready,
                 links[1].ready, links[0].ready}),
    .outValid  (1'b0),
    .outReady  (1'b0),
    .outFlit   ('0),
    .outSource ('0)
  );

  bind nocOutputPort nocOutputPort_checker #(.arbiterSide(1'b0)) u_outChecker
  (
    .clk       (clk),
    .rst       (rst),
    .state     (6'b000001),
    .valid     ('0),
    .ready     ('0),
    .outValid  (outValid),
    .outReady  (outReady),
    .outFlit   (outFlit),
    .outSource (outSource)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic takeRandomBit(output logic value);
    lfsr = lfsrStep(lfsr);
    value = lfsr[0];
  endtask

  function automatic int checkerErrors();
    return u_nocOutputPort.u_switchArbiter.u_arbChecker.failures
      + u_nocOutputPort.u_outChecker.failures;
  endfunction

  // Next requester after the last owner, in L, N, E, W, S order.
  function automatic int nextOwner(input int after);
    int idx;
    for (int k = 1; k <= numPorts; k++)
    begin
      idx = (after + k) % numPorts;
      if (recvPtr[idx] < streamLen[idx])
        return idx;
    end
    return after;
  endfunction

  function automatic logic phaseDone();
    for (int p = 0; p < numPorts; p++)
      if (recvPtr[p] < streamLen[p])
        return 1'b0;
    return 1'b1;
  endfunction

  task automatic checkResetState();
    assert (outValid === 1'b0)
    else
    begin
      valueErrors++;
      $display("ERROR: outValid got %h expected 0 around reset", outValid);
    end
    assert (inReady === '1)
    else
    begin
      valueErrors++;
      $display("ERROR: inReady got %h expected 1f around reset", inReady);
    end
  endtask

  task automatic loadPhase(inout int vi);
    int p;
    flags = vecMem[vi][2:0];
    readyPattern = vecMem[vi + 1][31:0];
    vi += 2;
    for (int i = 0; i < numPorts; i++)
    begin
      streamLen[i] = 0;
      sentPtr[i] = 0;
      recvPtr[i] = 0;
      portQuantum[i] = 0;
    end
    accepted = '0;
    phaseCycle = 0;
    inRun = 1'b0;
    runSource = portS;
    while (vecMem[vi][35:32] == 4'h3)
    begin
      p = int'(vecMem[vi][19:16]);
      stream[p][streamLen[p]] = vecMem[vi][15:0];
      if (vecMem[vi][15:13] == kindHead && int'(vecMem[vi][11:0]) > portQuantum[p])
        portQuantum[p] = int'(vecMem[vi][11:0]);
      streamLen[p]++;
      vi++;
    end
  endtask

  task automatic driveInputs();
    logic gap;
    logic stall;
    for (int p = 0; p < numPorts; p++)
    begin
      // A flit that is offered stays until taken.
      if (!inValid[p] || accepted[p])
      begin
        accepted[p] = 1'b0;
        gap = 1'b0;
        if (flags[1])
          takeRandomBit(gap);
        inValid[p] = (sentPtr[p] < streamLen[p]) && !gap;
        if (sentPtr[p] < streamLen[p])
          inFlit[p] = stream[p][sentPtr[p]];
      end
    end
    stall = 1'b0;
    if (flags[2])
      takeRandomBit(stall);
    outReady = readyPattern[phaseCycle % 32] && !stall;
    phaseCycle++;
  endtask

  task automatic sampleOutputs();
    int src;
    for (int p = 0; p < numPorts; p++)
    begin
      if (inValid[p] && inReady[p])
      begin
        accepted[p] = 1'b1;
        sentPtr[p]++;
      end
    end
    if (!outValid)
      inRun = 1'b0;
    else if (outReady)
    begin
      src = int'(outSource);
      if (flags[0])
      begin
        if (!inRun || src != runSource)
        begin
          assert (src == nextOwner(runSource))
          else
          begin
            orderErrors++;
            $display("ERROR: outSource got %h expected %h", src, nextOwner(runSource));
          end
          runSource = src;
          runLen = 0;
          inRun = 1'b1;
        end
        runLen++;
        assert (runLen <= portQuantum[src] + 1)
        else
        begin
          orderErrors++;
          $display("Source %0d kept the output for %0d flits, beyond its quantum of %0d",
                   src, runLen, portQuantum[src]);
        end
      end
      assert (src < numPorts && recvPtr[src] < streamLen[src])
      begin
        assert (outFlit == stream[src][recvPtr[src]])
        else
        begin
          valueErrors++;
          $display("ERROR: outFlit got %h expected %h from source %0d",
                   outFlit, stream[src][recvPtr[src]], src);
        end
        recvPtr[src]++;
      end
      else
      begin
        otherErrors++;
        $display("Flit %h arrived from source %0d, which had nothing left to send", outFlit, src);
      end
    end
  endtask

  task automatic printSummary();
    $display("Error counts: %0d value, %0d order, %0d other, %0d checker",
             valueErrors, orderErrors, otherErrors, checkerErrors());
  endtask

  initial
  begin
    int vi;
    int flitCount;
    rst = 1'b1;
    inValid = '0;
    inFlit = '0;
    outReady = 1'b0;
    accepted = '0;
    flags = '0;
    readyPattern = '0;
    lfsr = 32'ha3eb542a;
    phaseCycle = 0;
    valueErrors = 0;
    orderErrors = 0;
    otherErrors = 0;
    inRun = 1'b0;
    runSource = portS;
    runLen = 0;
    $readmemh("verif/nocOutputPort_vectors.txt", vecMem);
    flitCount = 0;
    for (int i = 0; i < vecWords; i++)
      if (vecMem[i][35:32] == 4'h3)
        flitCount++;
    cycleLimit = 40 * flitCount + 200;

    repeat (15)
    begin
      @(posedge clk);
      @(negedge clk);
      checkResetState();
    end
    @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    checkResetState();

    vi = 0;
    while (vecMem[vi][35:32] == 4'h1)
    begin
      loadPhase(vi);
      while (!phaseDone())
      begin
        @(posedge clk);
        #2;
        driveInputs();
        @(negedge clk);
        sampleOutputs();
      end
    end
    assert (vecMem[vi][35:32] == 4'hf)
    else
    begin
      otherErrors++;
      $display("Vector file has an unknown word at index %0d", vi);
    end

    // Nothing more may come out once all is delivered.
    repeat (8)
    begin
      @(posedge clk);
      #2;
      inValid = '0;
      outReady = 1'b1;
      @(negedge clk);
      assert (!outValid)
      else
      begin
        otherErrors++;
        $display("Extra flit %h appeared after all flits were delivered", outFlit);
      end
    end

    printSummary();
    if (valueErrors + orderErrors + otherErrors + checkerErrors() == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  initial
  begin
    #1;
    repeat (cycleLimit) @(posedge clk);
    otherErrors++;
    $display("Timeout, the run did not finish within %0d cycles", cycleLimit);
    printSummary();
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
common/nocPkg.sv
common/portLink.sv
inputPort/portFifo.sv
inputPort/holdTimer.sv
inputPort/inputPort.sv
arbiter/switchArbiter.sv
source/outputSlice.sv
source/nocOutputPort.sv
verif/nocOutputPort_checker.sv
verif/nocOutputPort_tb.sv

/* verif/nocOutputPort_vectors.txt */
// Each word is a tag digit and 32 data bits. Tag 1 is a phase with flags (bit 0 order checks,
// bit 1 random input gaps, bit 2 random stalls), tag 2 the outReady pattern, tag 3 a flit
// (port in data bits 19:16, flit in bits 15:0), tag f the end.
// All five ports loaded, quanta L0 N1 E2 W0 S3, outReady high.
1_0000_0001
2_ffff_ffff
3_0000_2000
3_0000_4011
3_0000_4012
3_0000_8013
3_0001_2001
3_0001_4021
3_0001_4022
3_0001_8023
3_0002_2002
3_0002_4031
3_0002_4032
3_0002_8033
3_0003_2000
3_0003_4041
3_0003_4042
3_0003_8043
3_0004_2003
3_0004_4051
3_0004_4052
3_0004_8053
// Random input gaps, patterned outReady.
1_0000_0002
2_db6d_b6db
3_0000_2002
3_0000_8061
3_0000_2000
3_0000_8062
3_0002_2001
3_0002_4071
3_0002_8072
// Random gaps and random stalls.
1_0000_0006
2_ffff_ffff
3_0001_2001
3_0001_4091
3_0001_8092
3_0003_2000
3_0003_80a1
3_0004_2003
3_0004_80b1
f_0000_0000
